// File: Makefile
# Verilator build for the MMU testbench

VERILATOR ?= verilator
TOP := tb_mmu
FILELIST := list.f
OBJ_DIR := obj_dir
LOG := sim.log
FLAGS := --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps
RUN_FLAGS := +verilator+error+limit+1000
PASS_TEXT := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/mmu_assert.sv
// MMU protocol assertions, bound into mmu
`timescale 1ns/100ps

module mmu_assert (
	input logic iCLOCK,
	input logic inRESET,
	input logic logic_req,
	input logic logic_lock,
	input logic mem_req,
	input logic mem_lock,
	input logic mem_table,
	input logic mem_mmu_use,
	input mmu_pkg::order_t mem_order,
	input logic mem_rw,
	input logic [31:0] mem_addr,
	input logic [31:0] mem_data,
	input logic page_fault
);
	import mmu_pkg::*;

	int failures = 0;

	// Memory outputs held under back-pressure
	hold_under_lock: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_req && mem_lock |=> mem_req && $stable(mem_addr) && $stable(mem_table)
			&& $stable(mem_mmu_use) && $stable(mem_order) && $stable(mem_rw)
			&& $stable(mem_data))
		else begin
			failures++;
			$error("memory outputs changed while mem_lock was high");
		end

	lock_after_accept: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		logic_req && !logic_lock |=> logic_lock)
		else begin
			failures++;
			$error("logic_lock not raised after an accepted request");
		end

	// Lock only drops after the data access or a fault
	lock_release: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$fell(logic_lock) |-> $past(mem_req && !mem_lock && !mem_table) || page_fault)
		else begin
			failures++;
			$error("logic_lock dropped while the request was still in flight");
		end

	table_read_format: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_req && mem_table |-> mem_order == ORDER_WORD64 && !mem_rw)
		else begin
			failures++;
			$error("table read without 64-bit order or with write set");
		end

	fault_pulse: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		page_fault |=> !page_fault)
		else begin
			failures++;
			$error("page_fault held longer than one cycle");
		end

	quiet_in_reset: assert property (@(posedge iCLOCK)
		!inRESET |-> !mem_req && !logic_lock && !page_fault)
		else begin
			failures++;
			$error("request, lock or fault active during reset");
		end

endmodule

bind mmu mmu_assert mmu_assert_inst (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.logic_req(logic_req),
	.logic_lock(logic_lock),
	.mem_req(mem_req),
	.mem_lock(mem_lock),
	.mem_table(mem_table),
	.mem_mmu_use(mem_mmu_use),
	.mem_order(mem_order),
	.mem_rw(mem_rw),
	.mem_addr(mem_addr),
	.mem_data(mem_data),
	.page_fault(page_fault)
);

// File: bench/page_memory.sv
// Behavioral page-table memory
// Sparse entry store, random lock stalls, 64-bit table read data
`timescale 1ns/100ps

module page_memory (
	input logic iCLOCK,
	input logic inRESET,
	input logic mem_req,
	input logic mem_table,
	input logic [31:0] mem_addr,
	output logic mem_lock,
	output logic mem_valid,
	output logic [63:0] mem_rdata
);
	logic [31:0] words [int unsigned];
	int seed = 32'h1f36;
	logic taken;
	logic [31:0] taken_addr;

	// Unwritten words read as invalid entries
	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (words.exists(addr)) begin
			return words[addr];
		end
		return 32'h0;
	endfunction

	task automatic write_entry(input logic [31:0] addr, input logic [31:0] value);
		words[addr] = value;
	endtask

	// Table read taken on an unlocked request
	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			taken <= 1'b0;
			taken_addr <= 32'h0;
		end
		else begin
			taken <= mem_req && mem_table && !mem_lock;
			taken_addr <= {mem_addr[31:3], 3'b000};
		end
	end

	// Outputs change on the falling edge
	always @(negedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			mem_lock <= 1'b0;
			mem_valid <= 1'b0;
			mem_rdata <= 64'h0;
		end
		else begin
			mem_lock <= ($random(seed) & 3) == 0;
			mem_valid <= taken;
			if (taken) begin
				mem_rdata <= {read_word(taken_addr + 32'd4), read_word(taken_addr)};
			end
		end
	end

endmodule

// File: bench/tb_mmu.sv
// MMU testbench
// Clock, reset, table setup, directed accesses, result checks, watchdog
`timescale 1ns/100ps

module tb_mmu;
	import mmu_pkg::*;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int REQUESTS = 9;
	localparam int CYCLE_BOUND = 60;

	// Directory bases, second-level tables and test pages
	localparam logic [31:0] PDT_ONE = 32'h0010_0000;
	localparam logic [31:0] PDT_TWO = 32'h0020_0000;
	localparam logic [31:0] TBL_OK = 32'h0040_0000;
	localparam logic [31:0] TBL_BAD = 32'h0040_8000;
	localparam logic [31:0] VA_ONE = 32'h1234_5678;
	localparam logic [31:0] VA_ONE_HIT = {VA_ONE[31:14], 14'h0123};
	localparam logic [31:0] VA_TWO = 32'h8765_4321;
	localparam logic [31:0] VA_TWO_HIT = {VA_TWO[31:14], 14'h3FF8};
	localparam logic [31:0] VA_FAULT_ONE = 32'h0400_1000;
	localparam logic [31:0] VA_FAULT_TWO = 32'hC012_3450;
	localparam logic [31:0] VA_BYPASS = 32'hDEAD_BEEC;
	localparam logic [17:0] FRAME_ONE = 18'h2_ABCD;
	localparam logic [17:0] FRAME_TWO = 18'h1_5A5A;
	localparam logic [12:0] FLAGS_ONE = 13'h0A5;
	localparam logic [12:0] FLAGS_TWO = 13'h1F0;

	logic iCLOCK;
	logic inRESET;
	logic tlb_flush;
	logic logic_req;
	mode_t logic_mode;
	logic [31:0] logic_pdt;
	order_t logic_order;
	logic logic_rw;
	logic [31:0] logic_addr;
	logic [31:0] logic_data;
	logic logic_lock;
	logic mem_req;
	logic mem_table;
	logic mem_mmu_use;
	order_t mem_order;
	logic mem_rw;
	logic [31:0] mem_addr;
	logic [31:0] mem_data;
	logic mem_lock;
	logic mem_valid;
	logic [63:0] mem_rdata;
	logic flags_valid;
	logic [12:0] flags;
	logic page_fault;

	// Transfers seen during the current request
	logic [31:0] table_q[$];
	logic [31:0] data_q[$];
	logic use_q[$];
	logic [12:0] flags_q[$];
	logic rw_q[$];
	logic [31:0] wdata_q[$];
	order_t order_q[$];
	logic valid_q[$];
	int faults;
	int errors = 0;

	mmu #(
		.TLB_ENTRIES(4)
	) mmu_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .tlb_flush(tlb_flush),
		.logic_req(logic_req), .logic_mode(logic_mode), .logic_pdt(logic_pdt),
		.logic_order(logic_order), .logic_rw(logic_rw), .logic_addr(logic_addr),
		.logic_data(logic_data), .logic_lock(logic_lock),
		.mem_req(mem_req), .mem_table(mem_table), .mem_mmu_use(mem_mmu_use),
		.mem_order(mem_order), .mem_rw(mem_rw), .mem_addr(mem_addr), .mem_data(mem_data),
		.mem_lock(mem_lock), .mem_valid(mem_valid), .mem_rdata(mem_rdata),
		.flags_valid(flags_valid), .flags(flags), .page_fault(page_fault)
	);

	page_memory mem_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .mem_req(mem_req), .mem_table(mem_table),
		.mem_addr(mem_addr), .mem_lock(mem_lock), .mem_valid(mem_valid),
		.mem_rdata(mem_rdata)
	);

	always #(PERIOD / 2) iCLOCK = ~iCLOCK;

	// Entry packs frame or table base, flags and valid bit
	function automatic logic [31:0] make_entry(input logic [17:0] frame,
		input logic [12:0] entry_flags, input logic valid);
		return {frame, entry_flags, valid};
	endfunction

	function automatic logic [31:0] one_level_addr(input logic [31:0] pdt, input logic [31:0] va);
		return pdt + {12'h0, va[31:14], 2'b00};
	endfunction

	function automatic logic [31:0] dir_addr(input logic [31:0] pdt, input logic [31:0] va);
		return pdt + {21'h0, va[31:23], 2'b00};
	endfunction

	function automatic logic [31:0] leaf_addr(input logic [31:0] base, input logic [31:0] va);
		return base + {21'h0, va[22:14], 2'b00};
	endfunction

	task automatic load_tables();
		mem_inst.write_entry(one_level_addr(PDT_ONE, VA_ONE),
			make_entry(FRAME_ONE, FLAGS_ONE, 1'b1));
		mem_inst.write_entry(dir_addr(PDT_TWO, VA_TWO),
			make_entry(TBL_OK[31:14], 13'h0, 1'b1));
		mem_inst.write_entry(leaf_addr(TBL_OK, VA_TWO),
			make_entry(FRAME_TWO, FLAGS_TWO, 1'b1));
		mem_inst.write_entry(one_level_addr(PDT_ONE, VA_FAULT_ONE),
			make_entry(18'h3_0000, 13'h1, 1'b0));
		mem_inst.write_entry(dir_addr(PDT_TWO, VA_FAULT_TWO),
			make_entry(TBL_BAD[31:14], 13'h0, 1'b1));
		mem_inst.write_entry(leaf_addr(TBL_BAD, VA_FAULT_TWO),
			make_entry(18'h3_1111, 13'h2, 1'b0));
	endtask

	// Completed memory transfers and fault pulses
	always @(posedge iCLOCK) begin
		if (inRESET && mem_req && !mem_lock) begin
			if (mem_table) begin
				table_q.push_back(mem_addr);
			end
			else begin
				data_q.push_back(mem_addr);
				use_q.push_back(mem_mmu_use);
				flags_q.push_back(flags);
				rw_q.push_back(mem_rw);
				wdata_q.push_back(mem_data);
				order_q.push_back(mem_order);
				valid_q.push_back(flags_valid);
			end
		end
		if (page_fault) begin
			faults++;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Starts on a falling edge and returns once the request has left
	task automatic run_access(input mode_t mode, input logic [31:0] pdt, input logic [31:0] va);
		table_q.delete();
		data_q.delete();
		use_q.delete();
		flags_q.delete();
		rw_q.delete();
		wdata_q.delete();
		order_q.delete();
		valid_q.delete();
		faults = 0;
		logic_req = 1'b1;
		logic_mode = mode;
		logic_pdt = pdt;
		logic_addr = va;
		logic_rw = ~logic_rw;
		logic_order = logic_order + 2'd1;
		logic_data = va ^ 32'hA5A5_5A5A;
		@(negedge iCLOCK);
		logic_req = 1'b0;
		while (logic_lock) begin
			@(negedge iCLOCK);
		end
		// One more edge so the fault pulse is counted
		@(negedge iCLOCK);
	endtask

	task automatic verify_access(input string name, input int n_tables, input logic [31:0] tbl0,
		input logic [31:0] tbl1, input int n_faults, input logic [31:0] exp_addr,
		input logic exp_use, input logic [12:0] exp_flags);
		int n_access;
		n_access = (n_faults == 0) ? 1 : 0;
		compare_value({name, " table reads"}, n_tables, table_q.size());
		if (n_tables > 0 && table_q.size() > 0) begin
			compare_value({name, " first table"}, tbl0, table_q[0]);
		end
		if (n_tables > 1 && table_q.size() > 1) begin
			compare_value({name, " second table"}, tbl1, table_q[1]);
		end
		compare_value({name, " faults"}, n_faults, faults);
		compare_value({name, " accesses"}, n_access, data_q.size());
		if (n_access > 0 && data_q.size() > 0) begin
			compare_value({name, " address"}, exp_addr, data_q[0]);
			compare_value({name, " mmu use"}, 32'(exp_use), 32'(use_q[0]));
			compare_value({name, " write flag"}, 32'(logic_rw), 32'(rw_q[0]));
			compare_value({name, " write data"}, logic_data, wdata_q[0]);
			compare_value({name, " order"}, 32'(logic_order), 32'(order_q[0]));
			compare_value({name, " flags valid"}, 32'(exp_use), 32'(valid_q[0]));
			if (exp_use) begin
				compare_value({name, " flags"}, 32'(exp_flags), 32'(flags_q[0]));
			end
		end
	endtask

	initial begin
		#((REQUESTS * CYCLE_BOUND + RESET_CYCLES) * PERIOD);
		$display("Timeout: the requests did not complete within the cycle bound");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		tlb_flush = 1'b0;
		logic_req = 1'b0;
		logic_mode = MODE_BYPASS;
		logic_pdt = 32'h0;
		logic_order = 2'd0;
		logic_rw = 1'b0;
		logic_addr = 32'h0;
		logic_data = 32'h0;
		load_tables();
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);

		run_access(MODE_ONE_LEVEL, PDT_ONE, VA_ONE);
		verify_access("one-level miss", 1, one_level_addr(PDT_ONE, VA_ONE), 32'h0, 0,
			{FRAME_ONE, VA_ONE[13:0]}, 1'b1, FLAGS_ONE);
		run_access(MODE_ONE_LEVEL, PDT_ONE, VA_ONE_HIT);
		verify_access("one-level hit", 0, 32'h0, 32'h0, 0,
			{FRAME_ONE, VA_ONE_HIT[13:0]}, 1'b1, FLAGS_ONE);
		run_access(MODE_TWO_LEVEL, PDT_TWO, VA_TWO);
		verify_access("two-level miss", 2, dir_addr(PDT_TWO, VA_TWO),
			leaf_addr(TBL_OK, VA_TWO), 0, {FRAME_TWO, VA_TWO[13:0]}, 1'b1, FLAGS_TWO);
		run_access(MODE_TWO_LEVEL, PDT_TWO, VA_TWO_HIT);
		verify_access("two-level hit", 0, 32'h0, 32'h0, 0,
			{FRAME_TWO, VA_TWO_HIT[13:0]}, 1'b1, FLAGS_TWO);
		run_access(MODE_ONE_LEVEL, PDT_ONE, VA_FAULT_ONE);
		verify_access("first-level fault", 1, one_level_addr(PDT_ONE, VA_FAULT_ONE), 32'h0, 1,
			32'h0, 1'b0, 13'h0);
		run_access(MODE_TWO_LEVEL, PDT_TWO, VA_FAULT_TWO);
		verify_access("second-level fault", 2, dir_addr(PDT_TWO, VA_FAULT_TWO),
			leaf_addr(TBL_BAD, VA_FAULT_TWO), 1, 32'h0, 1'b0, 13'h0);
		run_access(MODE_BYPASS, PDT_ONE, VA_BYPASS);
		verify_access("bypass", 0, 32'h0, 32'h0, 0, VA_BYPASS, 1'b0, 13'h0);

		// Cached pages must walk again after a flush
		tlb_flush = 1'b1;
		@(negedge iCLOCK);
		tlb_flush = 1'b0;
		run_access(MODE_ONE_LEVEL, PDT_ONE, VA_ONE);
		verify_access("flush one-level", 1, one_level_addr(PDT_ONE, VA_ONE), 32'h0, 0,
			{FRAME_ONE, VA_ONE[13:0]}, 1'b1, FLAGS_ONE);
		run_access(MODE_TWO_LEVEL, PDT_TWO, VA_TWO_HIT);
		verify_access("flush two-level", 2, dir_addr(PDT_TWO, VA_TWO),
			leaf_addr(TBL_OK, VA_TWO), 0, {FRAME_TWO, VA_TWO_HIT[13:0]}, 1'b1, FLAGS_TWO);

		$display("Checks done: %0d value errors, %0d assertion failures",
			errors, mmu_inst.mmu_assert_inst.failures);
		if (errors == 0 && mmu_inst.mmu_assert_inst.failures == 0) begin
			$display("Simulation completed successfully");
		end
		else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: list.f
rtl/mmu_pkg.sv
rtl/tlb.sv
rtl/page_walker.sv
rtl/mmu.sv
bench/page_memory.sv
bench/mmu_assert.sv
bench/tb_mmu.sv

// File: rtl/mmu.sv
// MMU top level
// Request latch, bypass/hit/walk control, memory port mux, lock
`timescale 1ns/100ps

module mmu #(
	parameter int TLB_ENTRIES = 8
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic tlb_flush,
	input logic logic_req,
	input mmu_pkg::mode_t logic_mode,
	input logic [mmu_pkg::ADDR_BITS-1:0] logic_pdt,
	input mmu_pkg::order_t logic_order,
	input logic logic_rw,
	input logic [mmu_pkg::ADDR_BITS-1:0] logic_addr,
	input logic [mmu_pkg::DATA_BITS-1:0] logic_data,
	output logic logic_lock,
	output logic mem_req,
	output logic mem_table,
	output logic mem_mmu_use,
	output mmu_pkg::order_t mem_order,
	output logic mem_rw,
	output logic [mmu_pkg::ADDR_BITS-1:0] mem_addr,
	output logic [mmu_pkg::DATA_BITS-1:0] mem_data,
	input logic mem_lock,
	input logic mem_valid,
	input logic [mmu_pkg::RDATA_BITS-1:0] mem_rdata,
	output logic flags_valid,
	output logic [mmu_pkg::FLAG_BITS-1:0] flags,
	output logic page_fault
);
	import mmu_pkg::*;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_LOOKUP,
		CTRL_WALK,
		CTRL_ACCESS
	} ctrl_state_t;

	ctrl_state_t ctrl_state;

	// Latched request
	mode_t req_mode;
	order_t req_order;
	logic req_rw;
	logic [ADDR_BITS-1:0] req_pdt;
	logic [ADDR_BITS-1:0] req_addr;
	logic [DATA_BITS-1:0] req_data;

	// Address and flags of the data access
	logic [ADDR_BITS-1:0] acc_addr;
	logic [FLAG_BITS-1:0] acc_flags;

	logic accept;
	logic translated;
	logic lookup_req;
	logic lookup_hit;
	logic [FRAME_BITS-1:0] hit_frame;
	logic [FLAG_BITS-1:0] hit_flags;
	logic fill_req;
	logic walk_start;
	logic tbl_req;
	logic [ADDR_BITS-1:0] tbl_addr;
	logic walk_done;
	logic walk_fault;
	logic [FRAME_BITS-1:0] walk_frame;
	logic [FLAG_BITS-1:0] walk_flags;

	assign accept = logic_req && !logic_lock;
	assign logic_lock = (ctrl_state != CTRL_IDLE);
	assign translated = (req_mode != MODE_BYPASS);

	// TLB probed on the acceptance edge, result seen in LOOKUP
	assign lookup_req = accept && (logic_mode != MODE_BYPASS);
	assign walk_start = (ctrl_state == CTRL_LOOKUP) && !lookup_hit;
	assign fill_req = (ctrl_state == CTRL_WALK) && walk_done && !walk_fault;

	tlb #(
		.TLB_ENTRIES(TLB_ENTRIES)
	) tlb_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(tlb_flush),
		.lookup_req(lookup_req),
		.lookup_addr(logic_addr),
		.fill_req(fill_req),
		.fill_addr(req_addr),
		.fill_frame(walk_frame),
		.fill_flags(walk_flags),
		.lookup_hit(lookup_hit),
		.hit_frame(hit_frame),
		.hit_flags(hit_flags)
	);

	page_walker walker_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.walk_start(walk_start),
		.walk_mode(req_mode),
		.walk_pdt(req_pdt),
		.walk_addr(req_addr),
		.mem_lock(mem_lock),
		.mem_valid(mem_valid),
		.mem_rdata(mem_rdata),
		.tbl_req(tbl_req),
		.tbl_addr(tbl_addr),
		.walk_done(walk_done),
		.walk_fault(walk_fault),
		.walk_frame(walk_frame),
		.walk_flags(walk_flags)
	);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ctrl_state <= CTRL_IDLE;
			page_fault <= 1'b0;
		end
		else begin
			page_fault <= 1'b0;
			case (ctrl_state)
				CTRL_IDLE: begin
					if (accept) begin
						ctrl_state <= (logic_mode == MODE_BYPASS) ? CTRL_ACCESS : CTRL_LOOKUP;
					end
				end
				CTRL_LOOKUP: begin
					ctrl_state <= lookup_hit ? CTRL_ACCESS : CTRL_WALK;
				end
				CTRL_WALK: begin
					if (walk_done) begin
						page_fault <= walk_fault;
						ctrl_state <= walk_fault ? CTRL_IDLE : CTRL_ACCESS;
					end
				end
				CTRL_ACCESS: begin
					// Done when memory takes the access
					if (!mem_lock) begin
						ctrl_state <= CTRL_IDLE;
					end
				end
				default: begin
					ctrl_state <= CTRL_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			req_mode <= logic_mode;
			req_order <= logic_order;
			req_rw <= logic_rw;
			req_pdt <= logic_pdt;
			req_addr <= logic_addr;
			req_data <= logic_data;
			acc_addr <= logic_addr;
		end
		if (ctrl_state == CTRL_LOOKUP && lookup_hit) begin
			acc_addr <= {hit_frame, req_addr[PAGE_BITS-1:0]};
			acc_flags <= hit_flags;
		end
		if (fill_req) begin
			acc_addr <= {walk_frame, req_addr[PAGE_BITS-1:0]};
			acc_flags <= walk_flags;
		end
	end

	// Walker owns the memory port during a walk
	always_comb begin
		if (ctrl_state == CTRL_WALK) begin
			mem_req = tbl_req;
			mem_table = 1'b1;
			mem_mmu_use = 1'b1;
			mem_order = ORDER_WORD64;
			mem_rw = 1'b0;
			mem_addr = tbl_addr;
		end
		else begin
			mem_req = (ctrl_state == CTRL_ACCESS);
			mem_table = 1'b0;
			mem_mmu_use = (ctrl_state == CTRL_ACCESS) && translated;
			mem_order = req_order;
			mem_rw = req_rw;
			mem_addr = acc_addr;
		end
	end

	assign mem_data = req_data;

	assign flags_valid = (ctrl_state == CTRL_ACCESS) && translated;
	assign flags = acc_flags;

endmodule

// File: rtl/mmu_pkg.sv
// Shared MMU definitions
// Mode and order codes, page-table entry layout, address index fields

package mmu_pkg;

	// Bus widths
	parameter int ADDR_BITS = 32;
	parameter int DATA_BITS = 32;
	parameter int RDATA_BITS = 64;
	parameter int ENTRY_BITS = 32;

	// 16 KB pages
	parameter int PAGE_BITS = 14;
	parameter int FRAME_BITS = 18;
	parameter int FLAG_BITS = 13;

	// Translation mode
	typedef logic [1:0] mode_t;

	parameter mode_t MODE_BYPASS = 2'd0;
	parameter mode_t MODE_ONE_LEVEL = 2'd1;
	parameter mode_t MODE_TWO_LEVEL = 2'd2;

	// Access size, passed through to memory
	typedef logic [1:0] order_t;

	parameter order_t ORDER_WORD64 = 2'd2;

	// Entry layout: valid, flags, frame or next table base
	parameter int ENTRY_VALID_BIT = 0;
	parameter int ENTRY_FLAGS_LSB = 1;
	parameter int ENTRY_FRAME_LSB = 14;

	// One-level index
	parameter int L1_INDEX_LSB = 14;
	parameter int L1_INDEX_BITS = 18;

	// Two-level directory and table indices
	parameter int L2_DIR_LSB = 23;
	parameter int L2_TBL_LSB = 14;
	parameter int L2_INDEX_BITS = 9;

	// Table entries are 4 bytes apart
	parameter int ENTRY_SHIFT = 2;

endpackage

// File: rtl/page_walker.sv
// Page-table walker
// One- or two-level walk with table reads and fault detection
`timescale 1ns/100ps

module page_walker (
	input logic iCLOCK,
	input logic inRESET,
	input logic walk_start,
	input mmu_pkg::mode_t walk_mode,
	input logic [mmu_pkg::ADDR_BITS-1:0] walk_pdt,
	input logic [mmu_pkg::ADDR_BITS-1:0] walk_addr,
	input logic mem_lock,
	input logic mem_valid,
	input logic [mmu_pkg::RDATA_BITS-1:0] mem_rdata,
	output logic tbl_req,
	output logic [mmu_pkg::ADDR_BITS-1:0] tbl_addr,
	output logic walk_done,
	output logic walk_fault,
	output logic [mmu_pkg::FRAME_BITS-1:0] walk_frame,
	output logic [mmu_pkg::FLAG_BITS-1:0] walk_flags
);
	import mmu_pkg::*;

	typedef enum logic [1:0] {
		WALK_IDLE,
		WALK_REQ,
		WALK_WAIT
	} walk_state_t;

	walk_state_t state;
	logic second_level;

	logic [ENTRY_BITS-1:0] entry;
	logic entry_valid;
	logic [ADDR_BITS-1:0] first_offset;
	logic [ADDR_BITS-1:0] second_offset;
	logic [ADDR_BITS-1:0] entry_base;
	logic [L1_INDEX_BITS-1:0] l1_index;
	logic [L2_INDEX_BITS-1:0] dir_index;
	logic [L2_INDEX_BITS-1:0] tbl_index;

	// The mmu holds mode, base and address for the whole walk
	assign l1_index = walk_addr[L1_INDEX_LSB +: L1_INDEX_BITS];
	assign dir_index = walk_addr[L2_DIR_LSB +: L2_INDEX_BITS];
	assign tbl_index = walk_addr[L2_TBL_LSB +: L2_INDEX_BITS];

	assign first_offset = (walk_mode == MODE_ONE_LEVEL) ?
		ADDR_BITS'(l1_index) << ENTRY_SHIFT : ADDR_BITS'(dir_index) << ENTRY_SHIFT;
	assign second_offset = ADDR_BITS'(tbl_index) << ENTRY_SHIFT;

	// 64-bit read, address bit 2 picks the half
	assign entry = tbl_addr[2] ? mem_rdata[RDATA_BITS-1:ENTRY_BITS] : mem_rdata[ENTRY_BITS-1:0];
	assign entry_valid = entry[ENTRY_VALID_BIT];

	// Directory entry points at a page-aligned table
	assign entry_base = {entry[ENTRY_FRAME_LSB +: FRAME_BITS], {PAGE_BITS{1'b0}}};

	assign tbl_req = (state == WALK_REQ);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= WALK_IDLE;
			second_level <= 1'b0;
			walk_done <= 1'b0;
			walk_fault <= 1'b0;
		end
		else begin
			walk_done <= 1'b0;
			walk_fault <= 1'b0;
			case (state)
				WALK_IDLE: begin
					if (walk_start) begin
						state <= WALK_REQ;
						second_level <= 1'b0;
					end
				end
				WALK_REQ: begin
					// Read accepted once lock drops
					if (!mem_lock) begin
						state <= WALK_WAIT;
					end
				end
				WALK_WAIT: begin
					if (mem_valid) begin
						if (!entry_valid) begin
							walk_done <= 1'b1;
							walk_fault <= 1'b1;
							state <= WALK_IDLE;
						end
						else if (!second_level && walk_mode == MODE_TWO_LEVEL) begin
							second_level <= 1'b1;
							state <= WALK_REQ;
						end
						else begin
							walk_done <= 1'b1;
							state <= WALK_IDLE;
						end
					end
				end
				default: begin
					state <= WALK_IDLE;
				end
			endcase
		end
	end

	// Table address and leaf result
	always_ff @(posedge iCLOCK) begin
		if (state == WALK_IDLE && walk_start) begin
			tbl_addr <= walk_pdt + first_offset;
		end
		if (state == WALK_WAIT && mem_valid) begin
			tbl_addr <= entry_base + second_offset;
			walk_frame <= entry[ENTRY_FRAME_LSB +: FRAME_BITS];
			walk_flags <= entry[ENTRY_FLAGS_LSB +: FLAG_BITS];
		end
	end

endmodule

// File: rtl/tlb.sv
// Fully associative TLB
// Registered lookup, round-robin fill, single-cycle flush
`timescale 1ns/100ps

module tlb #(
	parameter int TLB_ENTRIES = 8
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic lookup_req,
	input logic [mmu_pkg::ADDR_BITS-1:0] lookup_addr,
	input logic fill_req,
	input logic [mmu_pkg::ADDR_BITS-1:0] fill_addr,
	input logic [mmu_pkg::FRAME_BITS-1:0] fill_frame,
	input logic [mmu_pkg::FLAG_BITS-1:0] fill_flags,
	output logic lookup_hit,
	output logic [mmu_pkg::FRAME_BITS-1:0] hit_frame,
	output logic [mmu_pkg::FLAG_BITS-1:0] hit_flags
);
	import mmu_pkg::*;

	localparam int IDX_BITS = $clog2(TLB_ENTRIES);
	localparam int TAG_BITS = ADDR_BITS - PAGE_BITS;

	logic [TLB_ENTRIES-1:0] entry_valid;
	logic [TAG_BITS-1:0] entry_tag [TLB_ENTRIES];
	logic [FRAME_BITS-1:0] entry_frame [TLB_ENTRIES];
	logic [FLAG_BITS-1:0] entry_flags [TLB_ENTRIES];

	logic [IDX_BITS-1:0] victim;
	logic [IDX_BITS-1:0] victim_next;

	logic [TAG_BITS-1:0] lookup_tag;
	logic [TAG_BITS-1:0] fill_tag;
	logic lookup_match;
	logic [IDX_BITS-1:0] lookup_idx;
	logic fill_match;
	logic [IDX_BITS-1:0] fill_idx;
	logic [IDX_BITS-1:0] fill_slot;

	// Match flag in the top bit, entry index below
	function automatic logic [IDX_BITS:0] find_entry(input logic [TAG_BITS-1:0] tag);
		logic [IDX_BITS:0] result;
		result = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			if (entry_valid[i] && entry_tag[i] == tag) begin
				result = {1'b1, IDX_BITS'(i)};
			end
		end
		return result;
	endfunction

	assign lookup_tag = lookup_addr[ADDR_BITS-1:PAGE_BITS];
	assign fill_tag = fill_addr[ADDR_BITS-1:PAGE_BITS];

	assign {lookup_match, lookup_idx} = find_entry(lookup_tag);
	assign {fill_match, fill_idx} = find_entry(fill_tag);

	// Refill of a present page reuses its slot
	assign fill_slot = fill_match ? fill_idx : victim;

	assign victim_next = (victim == IDX_BITS'(TLB_ENTRIES - 1)) ? '0 : victim + 1'b1;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entry_valid <= '0;
			victim <= '0;
			lookup_hit <= 1'b0;
		end
		else if (flush) begin
			entry_valid <= '0;
			victim <= '0;
			lookup_hit <= 1'b0;
		end
		else begin
			lookup_hit <= lookup_req && lookup_match;
			if (fill_req) begin
				entry_valid[fill_slot] <= 1'b1;
				if (!fill_match) begin
					victim <= victim_next;
				end
			end
		end
	end

	// Entry contents and lookup result
	always_ff @(posedge iCLOCK) begin
		if (fill_req) begin
			entry_tag[fill_slot] <= fill_tag;
			entry_frame[fill_slot] <= fill_frame;
			entry_flags[fill_slot] <= fill_flags;
		end
		if (lookup_req) begin
			hit_frame <= entry_frame[lookup_idx];
			hit_flags <= entry_flags[lookup_idx];
		end
	end

endmodule
